// ==== Makefile ====
# Verilator build and run of the rv_core testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --timescale 1ns/1ps --top-module rv_tb \
		-f compile.f --Mdir obj_dir -o rv_tb_sim
	./obj_dir/rv_tb_sim

clean:
	rm -rf obj_dir

// ==== compile.f ====
+incdir+hw
+incdir+verif
hw/rv_pkg.sv
hw/rv_decoder.sv
hw/rv_regfile.sv
hw/rv_alu.sv
hw/rv_lsu.sv
hw/rv_core.sv
verif/tb_clock.sv
verif/rv_tb.sv

// ==== hw/rv_alu.sv ====
`timescale 1ns/1ps
`include "rv_settings.svh"

module rv_alu import rv_pkg::*; (
  input  alu_op_t alu_op,
  input  br_op_t  br_op,
  input  word_t   a,
  input  word_t   b,
  output word_t   result,
  output logic    taken
);

  logic [$clog2(`RV_XLEN)-1:0] shamt;
  logic                        lt_signed;
  logic                        lt_unsigned;
  logic                        equal;

  assign shamt = b[$clog2(`RV_XLEN)-1:0];
  assign lt_signed = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;
  assign equal = a == b;

  always_comb begin
    case (alu_op)
      alu_add:  result = a + b;
      alu_sub:  result = a - b;
      alu_sll:  result = a << shamt;
      alu_slt:  result = word_t'(lt_signed);
      alu_sltu: result = word_t'(lt_unsigned);
      alu_xor:  result = a ^ b;
      alu_srl:  result = a >> shamt;
      alu_sra:  result = $signed(a) >>> shamt;
      alu_or:   result = a | b;
      alu_and:  result = a & b;
      default:  result = a + b;
    endcase
  end

  // branch compare runs on the same operands, in parallel
  always_comb begin
    case (br_op)
      br_beq:  taken = equal;
      br_bne:  taken = !equal;
      br_blt:  taken = lt_signed;
      br_bge:  taken = !lt_signed;
      br_bltu: taken = lt_unsigned;
      br_bgeu: taken = !lt_unsigned;
      default: taken = 1'b0;
    endcase
  end

endmodule

// ==== hw/rv_core.sv ====
`timescale 1ns/1ps
`include "rv_settings.svh"

module rv_core import rv_pkg::*; (
  input  logic   clk,
  input  logic   reset,
  output logic   mem_valid,
  output logic   mem_instr,
  input  logic   mem_ready,
  output word_t  mem_addr,
  output word_t  mem_wdata,
  output wstrb_t mem_wstrb,
  input  word_t  mem_rdata,
  output logic   trap
);

  cpu_state_t state;
  word_t      pc;
  word_t      instr_q;
  word_t      wb_value;

  op_class_t  op_class;
  alu_op_t    alu_op;
  br_op_t     br_op;
  mem_size_t  mem_size;
  logic       load_unsigned;
  logic       use_imm;
  word_t      imm;
  reg_addr_t  rd;
  reg_addr_t  rs1;
  reg_addr_t  rs2;

  word_t      rs1_data;
  word_t      rs2_data;
  word_t      alu_a;
  word_t      alu_b;
  word_t      alu_result;
  logic       taken;

  logic       misaligned;
  wstrb_t     lsu_wstrb;
  word_t      lsu_wdata;
  word_t      load_data;

  word_t      pc_plus4;
  word_t      target;
  logic       target_bad;

  rv_decoder i_decoder (
    .instr         (instr_q),
    .op_class      (op_class),
    .alu_op        (alu_op),
    .br_op         (br_op),
    .mem_size      (mem_size),
    .load_unsigned (load_unsigned),
    .use_imm       (use_imm),
    .imm           (imm),
    .rd            (rd),
    .rs1           (rs1),
    .rs2           (rs2)
  );

  rv_regfile i_regfile (
    .clk      (clk),
    .reset    (reset),
    .rs1      (rs1),
    .rs2      (rs2),
    .we       (state == st_write_back),
    .rd       (rd),
    .wdata    (wb_value),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  // lui adds to zero, auipc to the pc
  always_comb begin
    case (op_class)
      cls_lui:   alu_a = '0;
      cls_auipc: alu_a = pc;
      default:   alu_a = rs1_data;
    endcase
  end
  assign alu_b = use_imm ? imm : rs2_data;

  rv_alu i_alu (
    .alu_op (alu_op),
    .br_op  (br_op),
    .a      (alu_a),
    .b      (alu_b),
    .result (alu_result),
    .taken  (taken)
  );

  // effective address is rs1 + imm from the alu
  rv_lsu i_lsu (
    .addr          (alu_result),
    .mem_size      (mem_size),
    .load_unsigned (load_unsigned),
    .store_data    (rs2_data),
    .rdata         (mem_rdata),
    .misaligned    (misaligned),
    .wstrb         (lsu_wstrb),
    .wdata         (lsu_wdata),
    .load_data     (load_data)
  );

  assign pc_plus4 = pc + word_t'(4);
  assign target = (op_class == cls_jalr) ? {alu_result[31:1], 1'b0} : pc + imm;
  assign target_bad = |target[1:0];

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_fetch;
      pc <= `RV_RESET_PC;
      mem_valid <= 1'b0;
      mem_instr <= 1'b0;
      mem_wstrb <= '0;
      trap <= 1'b0;
    end else begin
      case (state)
        st_fetch: begin
          mem_valid <= 1'b1;
          mem_instr <= 1'b1;
          mem_addr <= pc;
          mem_wstrb <= '0;
          state <= st_instr_wait;
        end
        st_instr_wait: begin
          if (mem_ready) begin
            mem_valid <= 1'b0;
            instr_q <= mem_rdata;
            state <= st_execute;
          end
        end
        st_execute: begin
          case (op_class)
            cls_lui, cls_auipc, cls_alu: begin
              wb_value <= alu_result;
              pc <= pc_plus4;
              state <= st_write_back;
            end
            cls_jal, cls_jalr: begin
              if (target_bad) begin
                state <= st_halted;
              end else begin
                wb_value <= pc_plus4;
                pc <= target;
                state <= st_write_back;
              end
            end
            cls_branch: begin
              // only a taken branch can fault on its target
              if (taken && target_bad) begin
                state <= st_halted;
              end else begin
                pc <= taken ? target : pc_plus4;
                state <= st_fetch;
              end
            end
            cls_load, cls_store: begin
              if (misaligned) begin
                state <= st_halted;
              end else begin
                mem_valid <= 1'b1;
                mem_instr <= 1'b0;
                mem_addr <= {alu_result[31:2], 2'b00};
                mem_wdata <= lsu_wdata;
                mem_wstrb <= (op_class == cls_store) ? lsu_wstrb : '0;
                pc <= pc_plus4;
                state <= st_mem_wait;
              end
            end
            default: state <= st_halted;
          endcase
        end
        st_mem_wait: begin
          if (mem_ready) begin
            mem_valid <= 1'b0;
            if (op_class == cls_load) begin
              wb_value <= load_data;
              state <= st_write_back;
            end else begin
              state <= st_fetch;
            end
          end
        end
        st_write_back: state <= st_fetch;
        st_halted: trap <= 1'b1;
        default: state <= st_halted;
      endcase
    end
  end

endmodule

// ==== hw/rv_decoder.sv ====
`timescale 1ns/1ps
`include "rv_settings.svh"

module rv_decoder import rv_pkg::*; (
  input  word_t     instr,
  output op_class_t op_class,
  output alu_op_t   alu_op,
  output br_op_t    br_op,
  output mem_size_t mem_size,
  output logic      load_unsigned,
  output logic      use_imm,
  output word_t     imm,
  output reg_addr_t rd,
  output reg_addr_t rs1,
  output reg_addr_t rs2
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_u;
  word_t      imm_j;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

  assign rs1 = instr[19:15];
  assign rs2 = instr[24:20];
  // no register write for branches and stores
  assign rd = (op_class == cls_branch || op_class == cls_store) ? '0 : instr[11:7];

  assign load_unsigned = funct3[2];

  always_comb begin
    case (funct3[1:0])
      2'b00:   mem_size = size_byte;
      2'b01:   mem_size = size_half;
      default: mem_size = size_word;
    endcase
  end

  always_comb begin
    op_class = cls_illegal;
    alu_op = alu_add;
    br_op = br_beq;
    use_imm = 1'b0;
    imm = imm_i;
    case (opcode)
      `RV_OP_LUI: begin
        op_class = cls_lui;
        use_imm = 1'b1;
        imm = imm_u;
      end
      `RV_OP_AUIPC: begin
        op_class = cls_auipc;
        use_imm = 1'b1;
        imm = imm_u;
      end
      `RV_OP_JAL: begin
        op_class = cls_jal;
        imm = imm_j;
      end
      `RV_OP_JALR: begin
        use_imm = 1'b1;
        if (funct3 == 3'b000) op_class = cls_jalr;
      end
      `RV_OP_BRANCH: begin
        imm = imm_b;
        op_class = cls_branch;
        case (funct3)
          3'b000:  br_op = br_beq;
          3'b001:  br_op = br_bne;
          3'b100:  br_op = br_blt;
          3'b101:  br_op = br_bge;
          3'b110:  br_op = br_bltu;
          3'b111:  br_op = br_bgeu;
          default: op_class = cls_illegal;
        endcase
      end
      `RV_OP_LOAD: begin
        use_imm = 1'b1;
        case (funct3)
          3'b000, 3'b001, 3'b010, 3'b100, 3'b101: op_class = cls_load;
          default: op_class = cls_illegal;
        endcase
      end
      `RV_OP_STORE: begin
        use_imm = 1'b1;
        imm = imm_s;
        if (funct3 < 3'b011) op_class = cls_store;
      end
      `RV_OP_IMM: begin
        use_imm = 1'b1;
        op_class = cls_alu;
        case (funct3)
          3'b000: alu_op = alu_add;
          3'b010: alu_op = alu_slt;
          3'b011: alu_op = alu_sltu;
          3'b100: alu_op = alu_xor;
          3'b110: alu_op = alu_or;
          3'b111: alu_op = alu_and;
          3'b001: begin
            alu_op = alu_sll;
            if (funct7 != 7'b0000000) op_class = cls_illegal;
          end
          default: begin
            alu_op = funct7[5] ? alu_sra : alu_srl;
            if ((funct7 & 7'b1011111) != 7'b0000000) op_class = cls_illegal;
          end
        endcase
      end
      `RV_OP_REG: begin
        op_class = cls_alu;
        case ({funct7, funct3})
          10'b0000000_000: alu_op = alu_add;
          10'b0100000_000: alu_op = alu_sub;
          10'b0000000_001: alu_op = alu_sll;
          10'b0000000_010: alu_op = alu_slt;
          10'b0000000_011: alu_op = alu_sltu;
          10'b0000000_100: alu_op = alu_xor;
          10'b0000000_101: alu_op = alu_srl;
          10'b0100000_101: alu_op = alu_sra;
          10'b0000000_110: alu_op = alu_or;
          10'b0000000_111: alu_op = alu_and;
          default:         op_class = cls_illegal;
        endcase
      end
      `RV_OP_SYSTEM: begin
        // only ecall and ebreak, told apart by instr[20]
        if ({instr[31:21], instr[19:7]} == '0) op_class = cls_system;
      end
      default: op_class = cls_illegal;
    endcase
  end

endmodule

// ==== hw/rv_lsu.sv ====
`timescale 1ns/1ps

module rv_lsu import rv_pkg::*; (
  input  word_t     addr,
  input  mem_size_t mem_size,
  input  logic      load_unsigned,
  input  word_t     store_data,
  input  word_t     rdata,
  output logic      misaligned,
  output wstrb_t    wstrb,
  output word_t     wdata,
  output word_t     load_data
);

  logic [1:0] lane;
  word_t      lane_data;
  logic       fill;

  assign lane = addr[1:0];

  always_comb begin
    case (mem_size)
      size_byte: misaligned = 1'b0;
      size_half: misaligned = lane[0];
      default:   misaligned = |lane;
    endcase
  end

  // stores replicate the data, the strobe picks the lanes
  always_comb begin
    case (mem_size)
      size_byte: begin
        wdata = {4{store_data[7:0]}};
        wstrb = 4'b0001 << lane;
      end
      size_half: begin
        wdata = {2{store_data[15:0]}};
        wstrb = lane[1] ? 4'b1100 : 4'b0011;
      end
      default: begin
        wdata = store_data;
        wstrb = 4'b1111;
      end
    endcase
  end

  // loads shift the addressed lane down to bit 0
  assign lane_data = rdata >> {lane, 3'b000};

  always_comb begin
    case (mem_size)
      size_byte: fill = !load_unsigned && lane_data[7];
      size_half: fill = !load_unsigned && lane_data[15];
      default:   fill = 1'b0;
    endcase
    case (mem_size)
      size_byte: load_data = {{24{fill}}, lane_data[7:0]};
      size_half: load_data = {{16{fill}}, lane_data[15:0]};
      default:   load_data = rdata;
    endcase
  end

endmodule

// ==== hw/rv_pkg.sv ====
`include "rv_settings.svh"

package rv_pkg;

  typedef logic [`RV_XLEN-1:0] word_t;
  typedef logic [$clog2(`RV_NREGS)-1:0] reg_addr_t;
  typedef logic [`RV_XLEN/8-1:0] wstrb_t;

  typedef enum logic [3:0] {
    cls_lui, cls_auipc, cls_jal, cls_jalr, cls_branch,
    cls_load, cls_store, cls_alu, cls_system, cls_illegal
  } op_class_t;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
    alu_xor, alu_srl, alu_sra, alu_or, alu_and
  } alu_op_t;

  typedef enum logic [2:0] {
    br_beq, br_bne, br_blt, br_bge, br_bltu, br_bgeu
  } br_op_t;

  // follows funct3[1:0] of loads and stores
  typedef enum logic [1:0] {
    size_byte, size_half, size_word
  } mem_size_t;

  typedef enum logic [2:0] {
    st_fetch, st_instr_wait, st_execute, st_mem_wait, st_write_back, st_halted
  } cpu_state_t;

endpackage

// ==== hw/rv_regfile.sv ====
`timescale 1ns/1ps
`include "rv_settings.svh"

module rv_regfile import rv_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  reg_addr_t rs1,
  input  reg_addr_t rs2,
  input  logic      we,
  input  reg_addr_t rd,
  input  word_t     wdata,
  output word_t     rs1_data,
  output word_t     rs2_data
);

  word_t regs [`RV_NREGS];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `RV_NREGS; i++) regs[i] <= '0;
    end else if (we && rd != '0) begin
      regs[rd] <= wdata;
    end
  end

  // x0 is never written, so it reads as zero
  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

endmodule

// ==== hw/rv_settings.svh ====
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

`define RV_XLEN     32
`define RV_NREGS    32
`define RV_RESET_PC 32'h0000_0000

// major opcodes, instr[6:0]
`define RV_OP_LUI    7'b0110111
`define RV_OP_AUIPC  7'b0010111
`define RV_OP_JAL    7'b1101111
`define RV_OP_JALR   7'b1100111
`define RV_OP_BRANCH 7'b1100011
`define RV_OP_LOAD   7'b0000011
`define RV_OP_STORE  7'b0100011
`define RV_OP_IMM    7'b0010011
`define RV_OP_REG    7'b0110011
`define RV_OP_SYSTEM 7'b1110011

`endif

// ==== verif/rv_ref_model.svh ====
`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH

// program layout, data reached with x0 as the base register
localparam int unsigned PROG_LEN  = 200;
localparam int unsigned DATA_BASE = 32'h600;
localparam int unsigned DUMP_BASE = 32'h700;

int unsigned gen_idx;

// architectural state of the model and the step it predicts
word_t       regs [32];
word_t       exp_pc;
word_t       exp_next_pc;
word_t       exp_addr;
word_t       exp_wdata;
word_t       exp_res;
wstrb_t      exp_strb;
reg_addr_t   exp_rd;
logic [2:0]  exp_f3;
logic [1:0]  exp_lane;
logic        exp_wr;
logic        exp_halt;
int unsigned exp_kind;

task automatic put_instr(input word_t w);
  mem[(`RV_RESET_PC >> 2) + gen_idx] = w;
  gen_idx++;
endtask

function automatic word_t enc_s(logic [11:0] imm, reg_addr_t rs2, reg_addr_t rs1,
                                logic [2:0] f3);
  return {imm[11:5], rs2, rs1, f3, imm[4:0], `RV_OP_STORE};
endfunction

function automatic word_t enc_b(logic [12:0] imm, reg_addr_t rs2, reg_addr_t rs1,
                                logic [2:0] f3);
  return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `RV_OP_BRANCH};
endfunction

function automatic word_t enc_j(logic [20:0] imm, reg_addr_t rd);
  return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `RV_OP_JAL};
endfunction

// offset into the data window, aligned to the access size
function automatic logic [11:0] data_offset(logic [1:0] size);
  logic [11:0] off;
  off = 12'(DATA_BASE) + 12'(pick_below(256));
  if (size == 2'd1) off[0] = 1'b0;
  if (size == 2'd2) off[1:0] = 2'b00;
  return off;
endfunction

task automatic put_random_alu();
  reg_addr_t  rd;
  reg_addr_t  ra;
  reg_addr_t  rb;
  logic [2:0] f3;
  logic [6:0] f7;
  rd = reg_addr_t'(pick_below(32));
  ra = reg_addr_t'(pick_below(32));
  rb = reg_addr_t'(pick_below(32));
  f3 = 3'(pick_below(8));
  if (pick_below(2) == 0) begin
    // sub and sra set bit 30
    f7 = ((f3 == 3'd0 || f3 == 3'd5) && pick_below(2) == 0) ? 7'h20 : 7'h00;
    put_instr({f7, rb, ra, f3, rd, `RV_OP_REG});
  end else if (f3 == 3'd1 || f3 == 3'd5) begin
    f7 = (f3 == 3'd5 && pick_below(2) == 0) ? 7'h20 : 7'h00;
    put_instr({f7, rb, ra, f3, rd, `RV_OP_IMM});
  end else begin
    put_instr({12'(pick_below(4096)), ra, f3, rd, `RV_OP_IMM});
  end
endtask

task automatic gen_random_program();
  int unsigned kind;
  int unsigned skip;
  reg_addr_t   rd;
  reg_addr_t   ra;
  reg_addr_t   rb;
  logic [2:0]  f3;
  gen_idx = 0;
  while (gen_idx < PROG_LEN) begin
    kind = pick_below(8);
    skip = 1 + pick_below(3);
    rd = reg_addr_t'(pick_below(32));
    ra = reg_addr_t'(pick_below(32));
    rb = reg_addr_t'(pick_below(32));
    // jumps need room for their skipped slots
    if (kind >= 5 && gen_idx + skip + 2 > PROG_LEN) kind = 0;
    case (kind)
      0, 1: put_random_alu();
      2: put_instr({20'(xorshift32()), rd, (pick_below(2) == 0) ? `RV_OP_LUI : `RV_OP_AUIPC});
      3: begin
        f3 = 3'(pick_below(5));
        if (f3 > 3'd2) f3 = f3 + 3'd1;
        put_instr({data_offset(f3[1:0]), 5'd0, f3, rd, `RV_OP_LOAD});
      end
      4: begin
        f3 = 3'(pick_below(3));
        put_instr(enc_s(data_offset(f3[1:0]), rb, 5'd0, f3));
      end
      5: begin
        f3 = 3'(pick_below(6));
        if (f3 > 3'd1) f3 = f3 + 3'd2;
        put_instr(enc_b(13'(4 * (skip + 1)), rb, ra, f3));
      end
      6: put_instr(enc_j(21'(4 * (skip + 1)), rd));
      default: begin
        // auipc gives the label base, jalr lands past the skipped slots
        ra = reg_addr_t'(1 + pick_below(31));
        put_instr({20'h00000, ra, `RV_OP_AUIPC});
        put_instr({12'(8 + 4 * skip), ra, 3'd0, rd, `RV_OP_JALR});
      end
    endcase
    if (kind >= 5) begin
      repeat (skip) put_random_alu();
    end
  end
  for (int k = 1; k < 32; k++) begin
    put_instr(enc_s(12'(DUMP_BASE + 4 * k), reg_addr_t'(k), 5'd0, 3'd2));
  end
  put_instr(32'h0000_0073);
endtask

function automatic word_t model_alu(logic [2:0] f3, logic alt, word_t a, word_t b);
  word_t r;
  case (f3)
    3'd0: r = alt ? a - b : a + b;
    3'd1: r = a << b[4:0];
    3'd2: r = {31'b0, $signed(a) < $signed(b)};
    3'd3: r = {31'b0, a < b};
    3'd4: r = a ^ b;
    3'd5: begin
      if (alt) r = $signed(a) >>> b[4:0];
      else r = a >> b[4:0];
    end
    3'd6: r = a | b;
    default: r = a & b;
  endcase
  return r;
endfunction

function automatic word_t load_value(word_t w, logic [1:0] lane, logic [2:0] f3);
  word_t s;
  s = w >> (8 * lane);
  case (f3)
    3'd0: return {{24{s[7]}}, s[7:0]};
    3'd1: return {{16{s[15]}}, s[15:0]};
    3'd4: return {24'b0, s[7:0]};
    3'd5: return {16'b0, s[15:0]};
    default: return w;
  endcase
endfunction

// one instruction at exp_pc, kind 1 is a load and 2 a store
task automatic model_step(input word_t ins);
  logic [2:0] f3;
  logic       cond;
  word_t      a;
  word_t      b;
  word_t      imm_i;
  word_t      ea;
  f3 = ins[14:12];
  a = regs[ins[19:15]];
  b = regs[ins[24:20]];
  imm_i = {{20{ins[31]}}, ins[31:20]};
  ea = '0;
  cond = 1'b0;
  exp_rd = ins[11:7];
  exp_f3 = f3;
  exp_wr = 1'b0;
  exp_halt = 1'b0;
  exp_kind = 0;
  exp_strb = '0;
  exp_wdata = '0;
  exp_next_pc = exp_pc + 32'd4;
  case (ins[6:0])
    `RV_OP_LUI: begin
      exp_wr = 1'b1;
      exp_res = {ins[31:12], 12'b0};
    end
    `RV_OP_AUIPC: begin
      exp_wr = 1'b1;
      exp_res = exp_pc + {ins[31:12], 12'b0};
    end
    `RV_OP_JAL: begin
      exp_wr = 1'b1;
      exp_res = exp_pc + 32'd4;
      exp_next_pc = exp_pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
    end
    `RV_OP_JALR: begin
      exp_wr = 1'b1;
      exp_res = exp_pc + 32'd4;
      exp_next_pc = (a + imm_i) & ~32'd1;
      if (f3 != 3'd0) exp_halt = 1'b1;
    end
    `RV_OP_BRANCH: begin
      case (f3)
        3'd0: cond = a == b;
        3'd1: cond = a != b;
        3'd4: cond = $signed(a) < $signed(b);
        3'd5: cond = $signed(a) >= $signed(b);
        3'd6: cond = a < b;
        3'd7: cond = a >= b;
        default: exp_halt = 1'b1;
      endcase
      if (cond) exp_next_pc = exp_pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
    end
    `RV_OP_LOAD: begin
      exp_wr = 1'b1;
      exp_kind = 1;
      ea = a + imm_i;
      if (f3 == 3'd3 || f3 > 3'd5) exp_halt = 1'b1;
    end
    `RV_OP_STORE: begin
      exp_kind = 2;
      ea = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
      if (f3 > 3'd2) exp_halt = 1'b1;
      case (f3[1:0])
        2'd0: begin
          exp_strb = 4'b0001 << ea[1:0];
          exp_wdata = {4{b[7:0]}};
        end
        2'd1: begin
          exp_strb = 4'b0011 << ea[1:0];
          exp_wdata = {2{b[15:0]}};
        end
        default: begin
          exp_strb = 4'b1111;
          exp_wdata = b;
        end
      endcase
    end
    `RV_OP_IMM: begin
      exp_wr = 1'b1;
      exp_res = model_alu(f3, f3 == 3'd5 && ins[30], a, imm_i);
    end
    `RV_OP_REG: begin
      exp_wr = 1'b1;
      exp_res = model_alu(f3, ins[30], a, b);
    end
    // ecall, ebreak and anything unknown stop the core
    default: exp_halt = 1'b1;
  endcase
  exp_lane = ea[1:0];
  exp_addr = {ea[31:2], 2'b00};
  if (exp_kind != 0 && f3[1:0] == 2'd1 && ea[0]) exp_halt = 1'b1;
  if (exp_kind != 0 && f3[1:0] == 2'd2 && ea[1:0] != 2'b00) exp_halt = 1'b1;
  if (exp_next_pc[1:0] != 2'b00) exp_halt = 1'b1;
endtask

`endif

// ==== verif/rv_tb.sv ====
`timescale 1ns/1ps
`include "rv_settings.svh"

module rv_tb import rv_pkg::*; ();

  localparam int unsigned REQ_TIMEOUT  = 64;
  localparam int unsigned HALT_TIMEOUT = 16;
  localparam int unsigned MAX_STEPS    = 2000;

  logic   clk;
  logic   reset;
  logic   mem_valid;
  logic   mem_instr;
  logic   mem_ready;
  word_t  mem_addr;
  word_t  mem_wdata;
  wstrb_t mem_wstrb;
  word_t  mem_rdata;
  logic   trap;

  // sparse memory keyed by word address
  word_t       mem [word_t];
  logic [31:0] rng_state;

  tb_clock i_clock (
    .clk (clk)
  );

  rv_core i_dut (
    .clk       (clk),
    .reset     (reset),
    .mem_valid (mem_valid),
    .mem_instr (mem_instr),
    .mem_ready (mem_ready),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_wstrb (mem_wstrb),
    .mem_rdata (mem_rdata),
    .trap      (trap)
  );

  function automatic logic [31:0] xorshift32();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  function automatic int unsigned pick_below(int unsigned n);
    return xorshift32() % n;
  endfunction

  `include "rv_ref_model.svh"

  task automatic stop_with_fail(input string why);
    $display("%s", why);
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_word(input string name, input word_t got, input word_t expected);
    if (got !== expected) begin
      stop_with_fail($sformatf("[FAIL] %s: got 0x%08h, expected 0x%08h", name, got, expected));
    end
  endtask

  task automatic check_strb(input string name, input wstrb_t got, input wstrb_t expected);
    if (got !== expected) begin
      stop_with_fail($sformatf("[FAIL] %s: got 0x%01h, expected 0x%01h", name, got, expected));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic expected);
    if (got !== expected) begin
      stop_with_fail($sformatf("[FAIL] %s: got 0x%01h, expected 0x%01h", name, got, expected));
    end
  endtask

  // unwritten words read back a pattern of their address
  function automatic word_t mem_read(word_t addr);
    if (mem.exists(addr >> 2)) return mem[addr >> 2];
    return (addr * 32'h9e37_79b1) ^ 32'h0bad_f00d;
  endfunction

  function automatic void mem_write(word_t addr, wstrb_t strb, word_t data);
    word_t w;
    w = mem_read(addr);
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) w[8*b +: 8] = data[8*b +: 8];
    end
    mem[addr >> 2] = w;
  endfunction

  // waits for one request, checks it while stalled, then answers it
  task automatic serve_request(input logic is_fetch, input word_t addr, input wstrb_t strb,
                               input word_t wdata, output word_t rdata);
    int unsigned waited;
    int unsigned stall;
    int unsigned s;
    waited = 0;
    while (mem_valid !== 1'b1) begin
      @(negedge clk);
      waited++;
      if (waited > REQ_TIMEOUT) stop_with_fail("the DUT made no memory request in time");
    end
    check_bit("trap", trap, 1'b0);
    stall = pick_below(4);
    for (s = 0; s <= stall; s++) begin
      check_bit("mem_valid", mem_valid, 1'b1);
      check_bit("mem_instr", mem_instr, is_fetch);
      check_word("mem_addr", mem_addr, addr);
      check_strb("mem_wstrb", mem_wstrb, strb);
      if (strb != '0) check_word("mem_wdata", mem_wdata, wdata);
      if (s < stall) @(negedge clk);
    end
    rdata = mem_read(addr);
    mem_ready = 1'b1;
    mem_rdata = rdata;
    @(negedge clk);
    mem_ready = 1'b0;
    mem_rdata = '0;
    if (strb != '0) mem_write(addr, strb, wdata);
  endtask

  task automatic expect_halt();
    int unsigned waited;
    waited = 0;
    while (trap !== 1'b1) begin
      check_bit("mem_valid", mem_valid, 1'b0);
      @(negedge clk);
      waited++;
      if (waited > HALT_TIMEOUT) stop_with_fail("trap did not rise after the halting instruction");
    end
    repeat (10) begin
      @(negedge clk);
      check_bit("mem_valid", mem_valid, 1'b0);
      check_bit("trap", trap, 1'b1);
    end
  endtask

  // three rising edges with reset high, released on the next falling edge
  task automatic apply_reset();
    reset = 1'b1;
    mem_ready = 1'b0;
    mem_rdata = '0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
  endtask

  // runs the program in mem in lockstep with the model
  task automatic run_program();
    word_t       ins;
    word_t       rdata;
    int unsigned steps;
    logic        done;
    for (int r = 0; r < 32; r++) regs[r] = '0;
    exp_pc = `RV_RESET_PC;
    steps = 0;
    done = 1'b0;
    apply_reset();
    while (!done) begin
      serve_request(1'b1, exp_pc, '0, '0, ins);
      model_step(ins);
      if (exp_halt) begin
        done = 1'b1;
      end else begin
        if (exp_kind == 1) begin
          serve_request(1'b0, exp_addr, '0, '0, rdata);
          exp_res = load_value(rdata, exp_lane, exp_f3);
        end else if (exp_kind == 2) begin
          serve_request(1'b0, exp_addr, exp_strb, exp_wdata, rdata);
        end
        if (exp_wr && exp_rd != 5'd0) regs[exp_rd] = exp_res;
        exp_pc = exp_next_pc;
        steps++;
        if (steps > MAX_STEPS) stop_with_fail("the program never reached a halting instruction");
      end
    end
    expect_halt();
  endtask

  // third instruction is lw from 0x602
  task automatic put_bad_load_program();
    gen_idx = 0;
    put_instr({12'h602, 5'd0, 3'd0, 5'd1, `RV_OP_IMM});
    put_instr({12'h003, 5'd0, 3'd0, 5'd2, `RV_OP_IMM});
    put_instr({12'h000, 5'd1, 3'd2, 5'd3, `RV_OP_LOAD});
    put_instr(32'h0000_0073);
  endtask

  // third instruction jumps to 0x102
  task automatic put_bad_jalr_program();
    gen_idx = 0;
    put_instr({12'h102, 5'd0, 3'd0, 5'd1, `RV_OP_IMM});
    put_instr({12'h007, 5'd0, 3'd0, 5'd2, `RV_OP_IMM});
    put_instr({12'h000, 5'd1, 3'd0, 5'd5, `RV_OP_JALR});
    put_instr(32'h0000_0073);
  endtask

  initial begin
    rng_state = 32'd8;
    reset = 1'b1;
    mem_ready = 1'b0;
    mem_rdata = '0;
    mem.delete();
    gen_random_program();
    run_program();
    check_word("halt_pc", exp_pc, word_t'(4 * (PROG_LEN + 31)));
    mem.delete();
    put_bad_load_program();
    run_program();
    check_word("halt_pc", exp_pc, 32'h0000_0008);
    mem.delete();
    put_bad_jalr_program();
    run_program();
    check_word("halt_pc", exp_pc, 32'h0000_0008);
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

// ==== verif/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
  parameter int HALF_PERIOD_NS = 10
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD_NS) clk = ~clk;
  end

endmodule
